// File: hw/riscv.sv
`timescale 1ns/100ps
`default_nettype none

module riscv (
  input  wire logic               clk,
  input  wire logic               arst_n,

  // program load port
  input  wire rv_isa_pkg::word_t  imem_addr,
  input  wire rv_isa_pkg::word_t  imem_wdata,
  input  wire logic               imem_we,

  input  wire logic               mmio_stall,  // freezes the whole pipe

  output rv_isa_pkg::word_t       mmio_addr,
  output rv_isa_pkg::word_t       mmio_wdata,
  input  wire rv_isa_pkg::word_t  mmio_rdata,
  output logic                    mmio_wen,
  output logic                    mmio_ren
);

  rv_pipe_pkg::fetch_t   fetch;
  rv_pipe_pkg::id_ex_t   id_ex_q;
  rv_pipe_pkg::ex_mem_t  ex_q;
  rv_pipe_pkg::mem_wb_t  wb_q;
  rv_isa_pkg::reg_idx_t  ra1, ra2;
  rv_isa_pkg::word_t     rd1, rd2;
  rv_isa_pkg::word_t     target;
  logic                  redirect;
  logic                  hold;

  rv_fetch fetch_i (
    .clk        (clk),
    .arst_n     (arst_n),
    .stall      (mmio_stall),
    .hold       (hold),
    .redirect   (redirect),
    .target     (target),
    .imem_addr  (imem_addr),
    .imem_wdata (imem_wdata),
    .imem_we    (imem_we),
    .fetch      (fetch)
  );

  rv_regfile regfile_i (
    .clk    (clk),
    .arst_n (arst_n),
    .ra1    (ra1),
    .ra2    (ra2),
    .rd1    (rd1),
    .rd2    (rd2),
    .wb     (wb_q),       // W stage write port
    .stall  (mmio_stall)
  );

  rv_decode decode_i (
    .clk     (clk),
    .arst_n  (arst_n),
    .stall   (mmio_stall),
    .flush   (redirect),  // taken branch or jump in X
    .fetch   (fetch),
    .rd1     (rd1),
    .rd2     (rd2),
    .ex_q    (ex_q),
    .wb_q    (wb_q),
    .ra1     (ra1),
    .ra2     (ra2),
    .hold    (hold),
    .id_ex_q (id_ex_q)
  );

  rv_execute execute_i (
    .clk      (clk),
    .arst_n   (arst_n),
    .stall    (mmio_stall),
    .id_ex_q  (id_ex_q),
    .redirect (redirect),
    .target   (target),
    .ex_q     (ex_q)
  );

  rv_mem_stage mem_i (
    .clk        (clk),
    .arst_n     (arst_n),
    .stall      (mmio_stall),
    .ex_q       (ex_q),
    .mmio_rdata (mmio_rdata),
    .mmio_addr  (mmio_addr),
    .mmio_wdata (mmio_wdata),
    .mmio_wen   (mmio_wen),
    .mmio_ren   (mmio_ren),
    .wb_q       (wb_q)
  );

endmodule

`default_nettype wire

// File: hw/rv_cfg.svh
`ifndef RV_CFG_SVH
`define RV_CFG_SVH

// first fetch address after reset
`define RV_RESET_PC 32'h0000_0000

// instruction memory depth is 2**9 words
`define RV_IMEM_AWIDTH 9

// data memory depth is 2**5 words
`define RV_DMEM_AWIDTH 5

// address[31:28] value that selects the MMIO window
`define RV_MMIO_NIBBLE 4'h8

`endif

// File: hw/rv_decode.sv
`timescale 1ns/100ps
`default_nettype none

module rv_decode (
  input  wire logic                  clk,
  input  wire logic                  arst_n,
  input  wire logic                  stall,
  input  wire logic                  flush,
  input  wire rv_pipe_pkg::fetch_t   fetch,
  input  wire rv_isa_pkg::word_t     rd1,
  input  wire rv_isa_pkg::word_t     rd2,
  input  wire rv_pipe_pkg::ex_mem_t  ex_q,
  input  wire rv_pipe_pkg::mem_wb_t  wb_q,
  output rv_isa_pkg::reg_idx_t       ra1,
  output rv_isa_pkg::reg_idx_t       ra2,
  output logic                       hold,
  output rv_pipe_pkg::id_ex_t        id_ex_q
);

  rv_isa_pkg::inst_t   inst;
  rv_isa_pkg::opcode_e opcode;
  rv_isa_pkg::funct3_t funct3;
  rv_isa_pkg::word_t   imm_i, imm_s, imm_b, imm_u, imm_j;
  rv_pipe_pkg::id_ex_t id_ex_d;
  logic                uses_rs1, uses_rs2;

  function automatic rv_pipe_pkg::alu_op_e alu_decode(input rv_isa_pkg::funct3_t f3,
                                                      input logic alt);
    case (f3)
      rv_isa_pkg::F3_ADD:  return alt ? rv_pipe_pkg::ALU_SUB : rv_pipe_pkg::ALU_ADD;
      rv_isa_pkg::F3_SLL:  return rv_pipe_pkg::ALU_SLL;
      rv_isa_pkg::F3_SLT:  return rv_pipe_pkg::ALU_SLT;
      rv_isa_pkg::F3_SLTU: return rv_pipe_pkg::ALU_SLTU;
      rv_isa_pkg::F3_XOR:  return rv_pipe_pkg::ALU_XOR;
      rv_isa_pkg::F3_SR:   return alt ? rv_pipe_pkg::ALU_SRA : rv_pipe_pkg::ALU_SRL;
      rv_isa_pkg::F3_OR:   return rv_pipe_pkg::ALU_OR;
      default:             return rv_pipe_pkg::ALU_AND;
    endcase
  endfunction

  // rs waits on any older valid writer still in X, M or W
  function automatic logic pending(input rv_isa_pkg::reg_idx_t rs,
                                   input rv_pipe_pkg::id_ex_t x,
                                   input rv_pipe_pkg::ex_mem_t m,
                                   input rv_pipe_pkg::mem_wb_t w);
    return (rs != '0) && ((x.valid && x.reg_write && x.rd == rs) ||
                          (m.valid && m.reg_write && m.rd == rs) ||
                          (w.valid && w.reg_write && w.rd == rs));
  endfunction

  assign inst   = fetch.inst;
  assign opcode = rv_isa_pkg::opcode_e'(inst[6:0]);
  assign funct3 = inst[14:12];
  assign ra1    = inst[19:15];
  assign ra2    = inst[24:20];

  assign imm_i = {{20{inst[31]}}, inst[31:20]};
  assign imm_s = {{20{inst[31]}}, inst[31:25], inst[11:7]};
  assign imm_b = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
  assign imm_u = {inst[31:12], 12'b0};
  assign imm_j = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};

  always_comb begin
    id_ex_d          = '0;
    id_ex_d.valid    = 1'b1;
    id_ex_d.pc       = fetch.pc;
    id_ex_d.rs1_val  = rd1;
    id_ex_d.rs2_val  = rd2;
    id_ex_d.funct3   = funct3;
    id_ex_d.rd       = inst[11:7];
    id_ex_d.b_is_imm = 1'b1;
    uses_rs1         = 1'b0;
    uses_rs2         = 1'b0;
    case (opcode)
      rv_isa_pkg::OP: begin
        id_ex_d.alu_op    = alu_decode(funct3, inst[30]);
        id_ex_d.b_is_imm  = 1'b0;
        id_ex_d.reg_write = 1'b1;
        uses_rs1          = 1'b1;
        uses_rs2          = 1'b1;
      end
      rv_isa_pkg::OP_IMM: begin
        // inst[30] only means sra here, addi has no subtract
        id_ex_d.alu_op    = alu_decode(funct3, inst[30] && funct3 == rv_isa_pkg::F3_SR);
        id_ex_d.imm       = imm_i;
        id_ex_d.reg_write = 1'b1;
        uses_rs1          = 1'b1;
      end
      rv_isa_pkg::LOAD: begin   // word only
        id_ex_d.imm       = imm_i;
        id_ex_d.mem_read  = 1'b1;
        id_ex_d.reg_write = 1'b1;
        id_ex_d.wb_sel    = rv_pipe_pkg::WB_MEM;
        uses_rs1          = 1'b1;
      end
      rv_isa_pkg::STORE: begin
        id_ex_d.imm       = imm_s;
        id_ex_d.mem_write = 1'b1;
        uses_rs1          = 1'b1;
        uses_rs2          = 1'b1;
      end
      rv_isa_pkg::BRANCH: begin
        id_ex_d.imm       = imm_b;
        id_ex_d.is_branch = 1'b1;
        uses_rs1          = 1'b1;
        uses_rs2          = 1'b1;
      end
      rv_isa_pkg::JAL: begin
        id_ex_d.imm       = imm_j;
        id_ex_d.is_jal    = 1'b1;
        id_ex_d.reg_write = 1'b1;
        id_ex_d.wb_sel    = rv_pipe_pkg::WB_PC4;
      end
      rv_isa_pkg::JALR: begin
        id_ex_d.imm       = imm_i;
        id_ex_d.is_jalr   = 1'b1;
        id_ex_d.reg_write = 1'b1;
        id_ex_d.wb_sel    = rv_pipe_pkg::WB_PC4;
        uses_rs1          = 1'b1;
      end
      rv_isa_pkg::LUI: begin
        id_ex_d.imm       = imm_u;
        id_ex_d.alu_op    = rv_pipe_pkg::ALU_PASS_B;
        id_ex_d.reg_write = 1'b1;
      end
      rv_isa_pkg::AUIPC: begin
        id_ex_d.imm       = imm_u;
        id_ex_d.a_is_pc   = 1'b1;
        id_ex_d.reg_write = 1'b1;
      end
      default: ;  // csr, fence, system: flows through doing nothing
    endcase
  end

  assign hold = fetch.valid &&
                ((uses_rs1 && pending(ra1, id_ex_q, ex_q, wb_q)) ||
                 (uses_rs2 && pending(ra2, id_ex_q, ex_q, wb_q)));

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      id_ex_q <= '0;
    end else if (!stall) begin
      if (flush || hold || !fetch.valid) begin
        id_ex_q <= '0;          // bubble
      end else begin
        id_ex_q <= id_ex_d;
      end
    end
  end

endmodule

`default_nettype wire

// File: hw/rv_execute.sv
`timescale 1ns/100ps
`default_nettype none

module rv_execute (
  input  wire logic                 clk,
  input  wire logic                 arst_n,
  input  wire logic                 stall,
  input  wire rv_pipe_pkg::id_ex_t  id_ex_q,
  output logic                      redirect,
  output rv_isa_pkg::word_t         target,
  output rv_pipe_pkg::ex_mem_t      ex_q
);

  rv_isa_pkg::word_t alu_a, alu_b, alu_y;
  rv_isa_pkg::word_t jalr_sum;
  logic              eq, lt, ltu, taken;

  assign alu_a = id_ex_q.a_is_pc  ? id_ex_q.pc  : id_ex_q.rs1_val;
  assign alu_b = id_ex_q.b_is_imm ? id_ex_q.imm : id_ex_q.rs2_val;

  always_comb begin
    case (id_ex_q.alu_op)
      rv_pipe_pkg::ALU_ADD:    alu_y = alu_a + alu_b;
      rv_pipe_pkg::ALU_SUB:    alu_y = alu_a - alu_b;
      rv_pipe_pkg::ALU_SLL:    alu_y = alu_a << alu_b[4:0];
      rv_pipe_pkg::ALU_SLT:    alu_y = {31'b0, $signed(alu_a) < $signed(alu_b)};
      rv_pipe_pkg::ALU_SLTU:   alu_y = {31'b0, alu_a < alu_b};
      rv_pipe_pkg::ALU_XOR:    alu_y = alu_a ^ alu_b;
      rv_pipe_pkg::ALU_SRL:    alu_y = alu_a >> alu_b[4:0];
      rv_pipe_pkg::ALU_SRA:    alu_y = $signed(alu_a) >>> alu_b[4:0];
      rv_pipe_pkg::ALU_OR:     alu_y = alu_a | alu_b;
      rv_pipe_pkg::ALU_AND:    alu_y = alu_a & alu_b;
      rv_pipe_pkg::ALU_PASS_B: alu_y = alu_b;
      default:                 alu_y = alu_a + alu_b;
    endcase
  end

  // comparator always on the register values
  assign eq  = id_ex_q.rs1_val == id_ex_q.rs2_val;
  assign lt  = $signed(id_ex_q.rs1_val) < $signed(id_ex_q.rs2_val);
  assign ltu = id_ex_q.rs1_val < id_ex_q.rs2_val;

  always_comb begin
    case (id_ex_q.funct3)
      rv_isa_pkg::F3_BEQ:  taken = eq;
      rv_isa_pkg::F3_BNE:  taken = !eq;
      rv_isa_pkg::F3_BLT:  taken = lt;
      rv_isa_pkg::F3_BGE:  taken = !lt;
      rv_isa_pkg::F3_BLTU: taken = ltu;
      rv_isa_pkg::F3_BGEU: taken = !ltu;
      default:             taken = 1'b0;
    endcase
  end

  assign jalr_sum = id_ex_q.rs1_val + id_ex_q.imm;
  assign target   = id_ex_q.is_jalr ? {jalr_sum[31:1], 1'b0} : id_ex_q.pc + id_ex_q.imm;
  assign redirect = id_ex_q.valid &&
                    (id_ex_q.is_jal || id_ex_q.is_jalr || (id_ex_q.is_branch && taken));

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      ex_q <= '0;
    end else if (!stall) begin
      ex_q.valid     <= id_ex_q.valid;
      ex_q.alu       <= alu_y;
      ex_q.sdata     <= id_ex_q.rs2_val;
      ex_q.pc4       <= id_ex_q.pc + 32'd4;
      ex_q.mem_read  <= id_ex_q.mem_read;
      ex_q.mem_write <= id_ex_q.mem_write;
      ex_q.reg_write <= id_ex_q.reg_write;
      ex_q.rd        <= id_ex_q.rd;
      ex_q.wb_sel    <= id_ex_q.wb_sel;
    end
  end

endmodule

`default_nettype wire

// File: hw/rv_fetch.sv
`timescale 1ns/100ps
`default_nettype none

`include "rv_cfg.svh"

module rv_fetch (
  input  wire logic               clk,
  input  wire logic               arst_n,
  input  wire logic               stall,
  input  wire logic               hold,
  input  wire logic               redirect,
  input  wire rv_isa_pkg::word_t  target,
  input  wire rv_isa_pkg::word_t  imem_addr,  // word index, not a byte address
  input  wire rv_isa_pkg::word_t  imem_wdata,
  input  wire logic               imem_we,
  output rv_pipe_pkg::fetch_t     fetch
);

  rv_isa_pkg::inst_t imem [0:(1 << `RV_IMEM_AWIDTH) - 1];

  rv_isa_pkg::word_t pc_q;
  rv_isa_pkg::word_t pc_f_q;   // pc of the word in inst_q
  rv_isa_pkg::inst_t inst_q;
  logic              valid_q;
  logic              advance;

  assign advance = !stall && !hold && !redirect;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      pc_q    <= `RV_RESET_PC;
      valid_q <= 1'b0;          // nothing fetched yet in the first cycle
    end else if (!stall) begin
      if (redirect) begin
        pc_q    <= target;
        valid_q <= 1'b0;        // kill the wrong-path word
      end else if (!hold) begin
        pc_q    <= pc_q + 32'd4;
        valid_q <= 1'b1;
      end
    end
  end

  // program load runs regardless of stall
  always_ff @(posedge clk) begin
    if (imem_we) begin
      imem[imem_addr[`RV_IMEM_AWIDTH-1:0]] <= imem_wdata;
    end
    if (advance) begin
      inst_q <= imem[pc_q[`RV_IMEM_AWIDTH+1:2]];  // sync read
      pc_f_q <= pc_q;
    end
  end

  assign fetch.valid = valid_q;
  assign fetch.pc    = pc_f_q;
  assign fetch.inst  = inst_q;

endmodule

`default_nettype wire

// File: hw/rv_isa_pkg.sv
`default_nettype none

package rv_isa_pkg;

  typedef logic [31:0] word_t;    // data and byte address
  typedef logic [4:0]  reg_idx_t;
  typedef logic [31:0] inst_t;
  typedef logic [2:0]  funct3_t;

  // base opcodes kept in this core, others decode as no-ops
  typedef enum logic [6:0] {
    OP     = 7'b0110011,
    OP_IMM = 7'b0010011,
    LOAD   = 7'b0000011,
    STORE  = 7'b0100011,
    BRANCH = 7'b1100011,
    JAL    = 7'b1101111,
    JALR   = 7'b1100111,
    LUI    = 7'b0110111,
    AUIPC  = 7'b0010111
  } opcode_e;

  // funct3 of OP and OP_IMM
  typedef enum logic [2:0] {
    F3_ADD  = 3'b000,  // sub when funct7[5] on OP
    F3_SLL  = 3'b001,
    F3_SLT  = 3'b010,
    F3_SLTU = 3'b011,
    F3_XOR  = 3'b100,
    F3_SR   = 3'b101,  // srl / sra by funct7[5]
    F3_OR   = 3'b110,
    F3_AND  = 3'b111
  } alu_funct3_e;

  // funct3 of BRANCH
  typedef enum logic [2:0] {
    F3_BEQ  = 3'b000,
    F3_BNE  = 3'b001,
    F3_BLT  = 3'b100,
    F3_BGE  = 3'b101,
    F3_BLTU = 3'b110,
    F3_BGEU = 3'b111
  } br_funct3_e;

endpackage

`default_nettype wire

// File: hw/rv_mem_stage.sv
`timescale 1ns/100ps
`default_nettype none

`include "rv_cfg.svh"

module rv_mem_stage (
  input  wire logic                  clk,
  input  wire logic                  arst_n,
  input  wire logic                  stall,
  input  wire rv_pipe_pkg::ex_mem_t  ex_q,
  input  wire rv_isa_pkg::word_t     mmio_rdata,
  output rv_isa_pkg::word_t          mmio_addr,
  output rv_isa_pkg::word_t          mmio_wdata,
  output logic                       mmio_wen,
  output logic                       mmio_ren,
  output rv_pipe_pkg::mem_wb_t       wb_q
);

  rv_isa_pkg::word_t dmem [0:(1 << `RV_DMEM_AWIDTH) - 1];

  logic [`RV_DMEM_AWIDTH-1:0] dmem_idx;
  rv_isa_pkg::word_t          dmem_rdata;
  rv_isa_pkg::word_t          load_data;
  rv_isa_pkg::word_t          wb_val;
  logic                       is_mmio;
  logic                       dmem_we;

  assign is_mmio  = ex_q.alu[31:28] == `RV_MMIO_NIBBLE;
  assign dmem_idx = ex_q.alu[`RV_DMEM_AWIDTH+1:2];  // word aligned only
  assign dmem_we  = ex_q.valid && ex_q.mem_write && !is_mmio;

  always_ff @(posedge clk) begin
    if (!stall && dmem_we) begin
      dmem[dmem_idx] <= ex_q.sdata;
    end
  end

  assign dmem_rdata = dmem[dmem_idx];  // async read, lands in wb_q

  // straight off the X/M register, so they freeze with it
  assign mmio_addr  = ex_q.alu;
  assign mmio_wdata = ex_q.sdata;
  assign mmio_wen   = ex_q.valid && ex_q.mem_write && is_mmio;
  assign mmio_ren   = ex_q.valid && ex_q.mem_read && is_mmio;

  assign load_data = is_mmio ? mmio_rdata : dmem_rdata;

  always_comb begin
    case (ex_q.wb_sel)
      rv_pipe_pkg::WB_MEM: wb_val = load_data;
      rv_pipe_pkg::WB_PC4: wb_val = ex_q.pc4;
      default:             wb_val = ex_q.alu;
    endcase
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      wb_q <= '0;
    end else if (!stall) begin
      wb_q.valid     <= ex_q.valid;
      wb_q.reg_write <= ex_q.reg_write;
      wb_q.rd        <= ex_q.rd;
      wb_q.wdata     <= wb_val;     // mmio_rdata sampled here
    end
  end

endmodule

`default_nettype wire

// File: hw/rv_pipe_pkg.sv
`default_nettype none

package rv_pipe_pkg;

  typedef enum logic [3:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_SLL,
    ALU_SLT,
    ALU_SLTU,
    ALU_XOR,
    ALU_SRL,
    ALU_SRA,
    ALU_OR,
    ALU_AND,
    ALU_PASS_B  // lui
  } alu_op_e;

  typedef enum logic [1:0] {
    WB_ALU,
    WB_MEM,
    WB_PC4
  } wb_sel_e;

  typedef struct packed {
    logic               valid;
    rv_isa_pkg::word_t  pc;
    rv_isa_pkg::inst_t  inst;
  } fetch_t;

  typedef struct packed {
    logic                valid;
    rv_isa_pkg::word_t   pc;
    rv_isa_pkg::word_t   rs1_val;
    rv_isa_pkg::word_t   rs2_val;
    rv_isa_pkg::word_t   imm;
    alu_op_e             alu_op;
    logic                a_is_pc;
    logic                b_is_imm;
    logic                is_branch;
    logic                is_jal;
    logic                is_jalr;
    rv_isa_pkg::funct3_t funct3;
    logic                mem_read;
    logic                mem_write;
    logic                reg_write;
    rv_isa_pkg::reg_idx_t rd;
    wb_sel_e             wb_sel;
  } id_ex_t;

  typedef struct packed {
    logic                 valid;
    rv_isa_pkg::word_t    alu;    // result, also the memory address
    rv_isa_pkg::word_t    sdata;  // store data
    rv_isa_pkg::word_t    pc4;    // link value
    logic                 mem_read;
    logic                 mem_write;
    logic                 reg_write;
    rv_isa_pkg::reg_idx_t rd;
    wb_sel_e              wb_sel;
  } ex_mem_t;

  typedef struct packed {
    logic                 valid;
    logic                 reg_write;
    rv_isa_pkg::reg_idx_t rd;
    rv_isa_pkg::word_t    wdata;
  } mem_wb_t;

endpackage

`default_nettype wire

// File: hw/rv_regfile.sv
`timescale 1ns/100ps
`default_nettype none

module rv_regfile (
  input  wire logic                  clk,
  input  wire logic                  arst_n,
  input  wire rv_isa_pkg::reg_idx_t  ra1,
  input  wire rv_isa_pkg::reg_idx_t  ra2,
  output rv_isa_pkg::word_t          rd1,
  output rv_isa_pkg::word_t          rd2,
  input  wire rv_pipe_pkg::mem_wb_t  wb,
  input  wire logic                  stall
);

  rv_isa_pkg::word_t regs_q [1:31];  // x0 has no storage

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      for (int i = 1; i < 32; i++) begin
        regs_q[i] <= '0;
      end
    end else if (!stall && wb.valid && wb.reg_write && wb.rd != '0) begin
      regs_q[wb.rd] <= wb.wdata;
    end
  end

  assign rd1 = (ra1 == '0) ? '0 : regs_q[ra1];
  assign rd2 = (ra2 == '0) ? '0 : regs_q[ra2];

endmodule

`default_nettype wire

// File: tb/clk_gen.sv
`timescale 1ns/100ps
`default_nettype none

module clk_gen (
  output logic clk,
  output logic arst_n
);

  localparam int HALF_PERIOD = 2;   // 4 ns clock
  localparam int RESET_CYCLES = 8;

  initial begin
    clk = 1'b0;
    forever #(HALF_PERIOD) clk = ~clk;
  end

  initial begin
    arst_n = 1'b1;
    #1 arst_n = 1'b0;               // falling edge starts the async reset
    repeat (RESET_CYCLES) @(posedge clk);
    arst_n <= 1'b1;
  end

endmodule

`default_nettype wire

// File: tb/riscv_stim.hex
// counts: program words, MMIO read values, expected MMIO writes
// then program words, MMIO read values, expected writes as address data pairs
00000037 00000002 0000000d
// 0x00 arithmetic, each result stored to the MMIO window at x31
80000fb7 00500093 ffd00113 002081b3  // lui x31, addi x1 5, addi x2 -3, add x3
003fa023 40208233 004fa223 00309293  // sw x3, sub x4, sw x4, slli x5
005fa423 40115313 006fa623 01c15393  // sw x5, srai x6, sw x6, srli x7
00112433 001134b3 0083c533 005565b3  // slt x8, sltu x9, xor x10, or x11
0375f613 009606b3 00dfa823 12345737  // andi x12, add x13, sw x13, lui x14
67870713 00efaa23 00001797 00ffac23  // addi x14, sw x14, auipc x15, sw x15
// 0x60 branches, the stores to offset 60 sit on paths that must be skipped
00108463 021fae23 00109463 00114463  // beq taken, skip, bne, blt taken
021fae23 00116463 0020d463 021fae23  // skip, bltu, bge taken, skip
0020f463 001fae23 00c0086f 021fae23  // bgeu, sw x1, jal x16, skip
021fae23 030fa023 0a800893 00188967  // skip, sw x16, addi x17, jalr x18 1(x17)
021fae23 021fae23 032fa223 04000993  // skip, skip, sw x18, addi x19 0x40
// 0xb0 data memory round trip, then two MMIO loads
00e9a023 0009aa03 001a0a13 034fa423  // sw x14, lw x20, addi x20, sw x20
040faa83 040fab03 416a8bb3 035fa623  // lw x21, lw x22, sub x23, sw x21
037fa823 0000006f 00000013           // sw x23, jal x0 0, nop
// MMIO read values
cafef00d 0000f00d
// expected MMIO writes
80000000 00000002  80000004 00000008  80000008 00000028
8000000c fffffffe  80000010 00000026  80000014 12345678
80000018 00001058  8000001c 00000005  80000020 0000008c
80000024 000000a0  80000028 12345679  8000002c cafef00d
80000030 cafe0000

// File: tb/riscv_tb.sv
`timescale 1ns/100ps
`default_nettype none

module riscv_tb;

  localparam int STIM_DEPTH      = 256;
  localparam int CYCLES_PER_WORD = 40;
  localparam int PROG_BASE       = 3;   // after the three counts

  logic              clk;
  logic              arst_n;
  rv_isa_pkg::word_t imem_addr;
  rv_isa_pkg::word_t imem_wdata;
  logic              imem_we;
  logic              mmio_stall;
  rv_isa_pkg::word_t mmio_addr;
  rv_isa_pkg::word_t mmio_wdata;
  rv_isa_pkg::word_t mmio_rdata;
  logic              mmio_wen;
  logic              mmio_ren;

  rv_isa_pkg::word_t stim [0:STIM_DEPTH-1];
  int                n_prog, n_rd, n_wr;
  int                rd_base, wr_base;
  int                wr_idx, rd_idx;     // next expected write, next read value
  int                run_cycles;
  int                stall_total;
  int                err_cnt;
  logic              running;
  logic [15:0]       lfsr;

  // outputs seen at the previous edge
  logic              prev_valid, prev_stall;
  rv_isa_pkg::word_t prev_addr, prev_wdata;
  logic              prev_wen, prev_ren;

  clk_gen clk_gen_i (
    .clk    (clk),
    .arst_n (arst_n)
  );

  riscv dut_i (
    .clk        (clk),
    .arst_n     (arst_n),
    .imem_addr  (imem_addr),
    .imem_wdata (imem_wdata),
    .imem_we    (imem_we),
    .mmio_stall (mmio_stall),
    .mmio_addr  (mmio_addr),
    .mmio_wdata (mmio_wdata),
    .mmio_rdata (mmio_rdata),
    .mmio_wen   (mmio_wen),
    .mmio_ren   (mmio_ren)
  );

  task automatic abort_run();
    err_cnt = err_cnt + 1;
    $display("Simulation finished: FAIL");
    $fatal(1, "stopped at the first error");
  endtask

  task automatic check_word(input string name, input rv_isa_pkg::word_t expected,
                            input rv_isa_pkg::word_t actual);
    assert (actual === expected) else begin
      $display("FAIL %0t ns: %s expected %08h got %08h", $time, name, expected, actual);
      abort_run();
    end
  endtask

  // 16-bit Galois LFSR, x^16 + x^14 + x^13 + x^11 + 1
  function automatic logic [15:0] lfsr_next(input logic [15:0] state);
    return state[0] ? ((state >> 1) ^ 16'hB400) : (state >> 1);
  endfunction

  task automatic take_bits(input int n, output int value);
    int i;
    value = 0;
    for (i = 0; i < n; i++) begin
      value = (value << 1) | lfsr[0];
      lfsr  = lfsr_next(lfsr);
    end
  endtask

  always @(posedge clk) begin
    if (!running) begin
      // reset and program load
      check_word("mmio_wen", 32'd0, {31'b0, mmio_wen});
      check_word("mmio_ren", 32'd0, {31'b0, mmio_ren});
    end else begin
      run_cycles <= run_cycles + 1;
      assert (run_cycles < CYCLES_PER_WORD * n_prog + stall_total) else begin
        $display("timeout: %0d of %0d MMIO writes seen after %0d cycles",
                 wr_idx, n_wr, run_cycles);
        abort_run();
      end
    end
    if (prev_valid && prev_stall) begin   // frozen since the last edge
      check_word("mmio_addr", prev_addr, mmio_addr);
      check_word("mmio_wdata", prev_wdata, mmio_wdata);
      check_word("mmio_wen", {31'b0, prev_wen}, {31'b0, mmio_wen});
      check_word("mmio_ren", {31'b0, prev_ren}, {31'b0, mmio_ren});
    end
    if (mmio_wen && !mmio_stall) begin
      assert (wr_idx < n_wr) else begin
        $display("MMIO write to %08h came after the last expected write", mmio_addr);
        abort_run();
      end
      check_word("mmio_addr", stim[wr_base + 2 * wr_idx], mmio_addr);
      check_word("mmio_wdata", stim[wr_base + 2 * wr_idx + 1], mmio_wdata);
      wr_idx <= wr_idx + 1;
    end
    if (mmio_ren && !mmio_stall) begin    // value taken on this edge
      assert (rd_idx < n_rd) else begin
        $display("MMIO read from %08h but no read values are left", mmio_addr);
        abort_run();
      end
      rd_idx     <= rd_idx + 1;
      mmio_rdata <= (rd_idx + 1 < n_rd) ? stim[rd_base + rd_idx + 1] : '0;
    end
    prev_valid <= arst_n;
    prev_stall <= mmio_stall;
    prev_addr  <= mmio_addr;
    prev_wdata <= mmio_wdata;
    prev_wen   <= mmio_wen;
    prev_ren   <= mmio_ren;
  end

  initial begin
    int i;
    int gap;
    int len;
    imem_addr   = '0;
    imem_wdata  = '0;
    imem_we     = 1'b0;
    mmio_stall  = 1'b1;   // pipe frozen until the program is in
    mmio_rdata  = '0;
    wr_idx      = 0;
    rd_idx      = 0;
    run_cycles  = 0;
    stall_total = 0;
    err_cnt     = 0;
    running     = 1'b0;
    prev_valid  = 1'b0;
    lfsr        = 16'd24;

    $readmemh("tb/riscv_stim.hex", stim);
    n_prog  = int'(stim[0]);
    n_rd    = int'(stim[1]);
    n_wr    = int'(stim[2]);
    rd_base = PROG_BASE + n_prog;
    wr_base = rd_base + n_rd;
    assert (n_prog > 0 && n_prog <= 512 && wr_base + 2 * n_wr <= STIM_DEPTH) else begin
      $display("stim file is missing or its counts are out of range");
      abort_run();
    end
    mmio_rdata = (n_rd > 0) ? stim[rd_base] : '0;

    wait (arst_n === 1'b0);
    wait (arst_n === 1'b1);
    for (i = 0; i < n_prog; i++) begin
      @(posedge clk);
      imem_addr  <= rv_isa_pkg::word_t'(i);   // word index
      imem_wdata <= stim[PROG_BASE + i];
      imem_we    <= 1'b1;
    end
    @(posedge clk);
    imem_we    <= 1'b0;
    mmio_stall <= 1'b0;
    running    <= 1'b1;

    // random stall bursts until every expected write is seen
    while (wr_idx < n_wr) begin
      take_bits(3, gap);
      repeat (gap + 2) @(posedge clk);
      if (wr_idx < n_wr) begin
        take_bits(2, len);
        stall_total <= stall_total + len + 1;
        mmio_stall  <= 1'b1;
        repeat (len + 1) @(posedge clk);
        mmio_stall  <= 1'b0;
      end
    end

    repeat (8) @(posedge clk);   // room for a stray write to show up
    assert (rd_idx == n_rd) else begin
      $display("only %0d of %0d MMIO read values were consumed", rd_idx, n_rd);
      abort_run();
    end
    if (err_cnt == 0) begin
      $display("Simulation finished: PASS");
      $finish;
    end else begin
      abort_run();
    end
  end

endmodule

`default_nettype wire

// File: vlog.f
+incdir+hw
hw/rv_isa_pkg.sv
hw/rv_pipe_pkg.sv
hw/rv_fetch.sv
hw/rv_regfile.sv
hw/rv_decode.sv
hw/rv_execute.sv
hw/rv_mem_stage.sv
hw/riscv.sv
tb/clk_gen.sv
tb/riscv_tb.sv
